/* source/conv_pkg.sv */
package conv_pkg;

    // window is KERNEL x KERNEL, one pe_row per window row
    localparam int KERNEL = 3;

    // signed ifmap pixel
    typedef logic signed [7:0] pixel_t;

    // signed kernel weight
    typedef logic signed [7:0] weight_t;

    // dot product of one pe_row
    // worst case 3 * 128 * 128 still fits in 18 bits
    typedef logic signed [17:0] row_sum_t;

    // final ofmap value after the partial-sum adder
    typedef logic signed [19:0] ofmap_t;

    // one incoming column, row 0 in the low bits
    typedef pixel_t [KERNEL-1:0] column_t;

    // weights of one pe_row, window column 0 (oldest) in the low bits
    typedef weight_t [KERNEL-1:0] weight_row_t;

    // selects the pe_row that a weight load goes to
    typedef logic [1:0] row_index_t;

endpackage

/* source/window_if.sv */
`timescale 1ns/100ps

interface window_if;

    // one window row per tap, oldest column in the low bits
    conv_pkg::pixel_t [conv_pkg::KERNEL-1:0] tap_row0;
    conv_pkg::pixel_t [conv_pkg::KERNEL-1:0] tap_row1;
    conv_pkg::pixel_t [conv_pkg::KERNEL-1:0] tap_row2;

    // one-cycle pulse, window holds a full set of columns
    logic window_valid;

    modport producer (
        output tap_row0,
        output tap_row1,
        output tap_row2,
        output window_valid
    );

    modport consumer (
        input tap_row0,
        input tap_row1,
        input tap_row2,
        input window_valid
    );

endinterface

/* source/window_buffer.sv */
`timescale 1ns/100ps

module window_buffer #(
    parameter int NUM_ROWS = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              shift_en,
    input  logic              start_row,
    input  conv_pkg::column_t column_in,
    window_if.producer        win
);

    localparam int CNT_W = $clog2(conv_pkg::KERNEL + 1);

    // column shift register, index 0 is the oldest column
    conv_pkg::column_t [conv_pkg::KERNEL-1:0] cols;

    // window regrouped by row for the pe_row taps
    conv_pkg::pixel_t [NUM_ROWS-1:0][conv_pkg::KERNEL-1:0] rows;

    logic [CNT_W-1:0] fill_cnt;
    logic [CNT_W-1:0] fill_next;

    // newest column enters at the high end
    always_ff @(posedge clk) begin
        if (shift_en) begin
            cols <= {column_in, cols[conv_pkg::KERNEL-1:1]};
        end
    end

    // start_row restarts the band, a column in the same cycle counts as the first
    always_comb begin
        fill_next = fill_cnt;
        if (start_row) begin
            fill_next = shift_en ? CNT_W'(1) : '0;
        end else if (shift_en && (fill_cnt < CNT_W'(conv_pkg::KERNEL))) begin
            fill_next = fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fill_cnt         <= '0;
            win.window_valid <= 1'b0;
        end else begin
            fill_cnt         <= fill_next;
            win.window_valid <= shift_en && (fill_next >= CNT_W'(conv_pkg::KERNEL));
        end
    end

    // transpose columns into rows
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL; c++) begin
                rows[r][c] = cols[c][r];
            end
        end
    end

    assign win.tap_row0 = rows[0];
    assign win.tap_row1 = rows[1];
    assign win.tap_row2 = rows[2];

endmodule

/* source/pe_row.sv */
`timescale 1ns/100ps

module pe_row #(
    parameter int ROW_INDEX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  weight_en,
    input  conv_pkg::row_index_t  weight_row,
    input  conv_pkg::weight_row_t weights_in,
    window_if.consumer            win,
    output conv_pkg::row_sum_t    row_sum,
    output logic                  sum_valid
);

    conv_pkg::weight_row_t weights;

    // this row's slice of the window
    conv_pkg::pixel_t [conv_pkg::KERNEL-1:0] tap;

    conv_pkg::row_sum_t dot;
    logic               load_hit;

    assign load_hit = weight_en && (weight_row == conv_pkg::row_index_t'(ROW_INDEX));

    // weights come up as zero after reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            weights <= '0;
        end else if (load_hit) begin
            weights <= weights_in;
        end
    end

    always_comb begin
        case (ROW_INDEX)
            0:       tap = win.tap_row0;
            1:       tap = win.tap_row1;
            default: tap = win.tap_row2;
        endcase
    end

    // signed dot product, oldest column against weight column 0
    always_comb begin
        dot = '0;
        for (int c = 0; c < conv_pkg::KERNEL; c++) begin
            dot = dot + tap[c] * weights[c];
        end
    end

    always_ff @(posedge clk) begin
        if (win.window_valid) begin
            row_sum <= dot;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= win.window_valid;
        end
    end

endmodule

/* source/psum_adder.sv */
`timescale 1ns/100ps

module psum_adder #(
    parameter int NUM_ROWS = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  conv_pkg::row_sum_t [NUM_ROWS-1:0] row_sums,
    input  logic [NUM_ROWS-1:0]                sums_valid,
    output conv_pkg::ofmap_t                   ofmap_out,
    output logic                               ofmap_valid
);

    conv_pkg::ofmap_t total;
    logic             all_valid;

    // rows run in lockstep, so all valids rise together
    assign all_valid = &sums_valid;

    // sign-extend each row sum before adding
    always_comb begin
        total = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total = total + conv_pkg::ofmap_t'(row_sums[r]);
        end
    end

    // output holds its value between results
    always_ff @(posedge clk) begin
        if (all_valid) begin
            ofmap_out <= total;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ofmap_valid <= 1'b0;
        end else begin
            ofmap_valid <= all_valid;
        end
    end

endmodule

/* source/conv_engine.sv */
`timescale 1ns/100ps

module conv_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  shift_en,
    input  logic                  start_row,
    input  logic                  weight_en,
    input  conv_pkg::column_t     column_in,
    input  conv_pkg::row_index_t  weight_row,
    input  conv_pkg::weight_row_t weights_in,
    output conv_pkg::ofmap_t      ofmap_out,
    output logic                  ofmap_valid
);

    // one pe_row per window row
    localparam int NUM_ROWS = conv_pkg::KERNEL;

    conv_pkg::row_sum_t [NUM_ROWS-1:0] row_sums;
    logic [NUM_ROWS-1:0]               sums_valid;

    window_if win ();

    window_buffer #(
        .NUM_ROWS (NUM_ROWS)
    ) u_window_buffer (
        .clk       (clk),
        .rst       (rst),
        .shift_en  (shift_en),
        .start_row (start_row),
        .column_in (column_in),
        .win       (win)
    );

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_pe_row
        pe_row #(
            .ROW_INDEX (r)
        ) u_pe_row (
            .clk        (clk),
            .rst        (rst),
            .weight_en  (weight_en),
            .weight_row (weight_row),
            .weights_in (weights_in),
            .win        (win),
            .row_sum    (row_sums[r]),
            .sum_valid  (sums_valid[r])
        );
    end

    psum_adder #(
        .NUM_ROWS (NUM_ROWS)
    ) u_psum_adder (
        .clk         (clk),
        .rst         (rst),
        .row_sums    (row_sums),
        .sums_valid  (sums_valid),
        .ofmap_out   (ofmap_out),
        .ofmap_valid (ofmap_valid)
    );

endmodule

/* verif/conv_stim.svh */
`ifndef CONV_STIM_SVH
`define CONV_STIM_SVH

// columns: shift, start_row, weight_en, random fill, column_in, weight_row, weights_in, expect
// random fill replaces column_in and weights_in with values from $random
localparam int STIM_LEN = 34;

stim_t stim_table [STIM_LEN] = '{
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b1, 1'b0, 24'h00_00_00, 2'd0, 24'h01_02_03, 1'b0},
    '{1'b0, 1'b0, 1'b1, 1'b0, 24'h00_00_00, 2'd1, 24'hff_01_fe, 1'b0},
    '{1'b0, 1'b0, 1'b1, 1'b0, 24'h00_00_00, 2'd2, 24'h04_fd_02, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    // first band, output from the third column on
    '{1'b1, 1'b1, 1'b0, 1'b0, 24'h05_fb_0a, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b0, 24'h80_7f_81, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b1, 1'b0, 1'b0, 1'b0, 24'h7f_80_7f, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    // reload row 1 between shifts
    '{1'b0, 1'b0, 1'b1, 1'b1, 24'h00_00_00, 2'd1, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b1, 1'b0, 1'b1, 1'b0, 24'h80_80_80, 2'd0, 24'h80_80_80, 1'b1},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    // new band without a column
    '{1'b0, 1'b1, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    '{1'b1, 1'b1, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b1, 1'b0, 1'b1, 1'b1, 24'h00_00_00, 2'd2, 24'h00_00_00, 1'b1},
    '{1'b1, 1'b0, 1'b0, 1'b1, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b1},
    // row index 3 has no pe_row, load is ignored
    '{1'b1, 1'b0, 1'b1, 1'b1, 24'h00_00_00, 2'd3, 24'h00_00_00, 1'b1},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0},
    '{1'b0, 1'b0, 1'b0, 1'b0, 24'h00_00_00, 2'd0, 24'h00_00_00, 1'b0}
};

`endif

/* verif/conv_engine_tb.sv */
`timescale 1ns/100ps

module conv_engine_tb;

    typedef struct packed {
        logic                  shift;
        logic                  start;
        logic                  wen;
        logic                  rnd;
        conv_pkg::column_t     column;
        conv_pkg::row_index_t  wrow;
        conv_pkg::weight_row_t weights;
        logic                  exp_out;
    } stim_t;

    `include "conv_stim.svh"

    logic                  clk;
    logic                  rst;
    logic                  shift_en;
    logic                  start_row;
    logic                  weight_en;
    conv_pkg::column_t     column_in;
    conv_pkg::row_index_t  weight_row;
    conv_pkg::weight_row_t weights_in;
    conv_pkg::ofmap_t      ofmap_out;
    logic                  ofmap_valid;

    int seed;
    int edge_cnt = 0;
    int err_value = 0;
    int err_timing = 0;
    int err_extra = 0;
    int err_missing = 0;
    int err_table = 0;

    // expected results and the edge count at which each must show up
    int exp_value_q [$];
    int exp_due_q [$];

    // reference model with column 0 as the oldest
    conv_pkg::column_t     model_cols [conv_pkg::KERNEL];
    conv_pkg::weight_row_t model_w [conv_pkg::KERNEL];
    int                    model_fill;

    conv_engine u_conv_engine (
        .clk         (clk),
        .rst         (rst),
        .shift_en    (shift_en),
        .start_row   (start_row),
        .weight_en   (weight_en),
        .column_in   (column_in),
        .weight_row  (weight_row),
        .weights_in  (weights_in),
        .ofmap_out   (ofmap_out),
        .ofmap_valid (ofmap_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic drive_inputs(input stim_t s);
        shift_en   = s.shift;
        start_row  = s.start;
        weight_en  = s.wen;
        column_in  = s.column;
        weight_row = s.wrow;
        weights_in = s.weights;
    endtask

    // weights update first so a load in a shift cycle counts for that shift
    function automatic bit update_model(input stim_t s);
        if (s.wen && int'(s.wrow) < conv_pkg::KERNEL) begin
            model_w[s.wrow] = s.weights;
        end
        if (s.shift) begin
            for (int c = 0; c < conv_pkg::KERNEL - 1; c++) begin
                model_cols[c] = model_cols[c + 1];
            end
            model_cols[conv_pkg::KERNEL - 1] = s.column;
        end
        if (s.start) begin
            model_fill = s.shift ? 1 : 0;
        end else if (s.shift && model_fill < conv_pkg::KERNEL) begin
            model_fill++;
        end
        return s.shift && (model_fill >= conv_pkg::KERNEL);
    endfunction

    function automatic int expected_ofmap();
        int acc;
        acc = 0;
        for (int r = 0; r < conv_pkg::KERNEL; r++) begin
            for (int c = 0; c < conv_pkg::KERNEL; c++) begin
                acc += int'(model_cols[c][r]) * int'(model_w[r][c]);
            end
        end
        return acc;
    endfunction

    // outputs sampled mid-cycle away from the rising edge
    always @(negedge clk) begin : monitor
        int want_value;
        int want_due;
        if (ofmap_valid) begin
            assert (exp_value_q.size() > 0) else begin
                err_extra++;
                $display("** Error at %0d ns: ofmap_valid with no result expected", $time);
            end
            if (exp_value_q.size() > 0) begin
                want_value = exp_value_q.pop_front();
                want_due   = exp_due_q.pop_front();
                assert (int'(ofmap_out) == want_value) else begin
                    err_value++;
                    $display("** Error at %0d ns: ofmap_out %0d, expected %0d",
                             $time, ofmap_out, want_value);
                end
                assert (edge_cnt == want_due) else begin
                    err_timing++;
                    $display("** Error at %0d ns: result at edge %0d, expected at edge %0d",
                             $time, edge_cnt, want_due);
                end
            end
        end else if (exp_due_q.size() > 0) begin
            assert (exp_due_q[0] > edge_cnt) else begin
                err_missing++;
                $display("** Error at %0d ns: expected result %0d did not arrive",
                         $time, exp_value_q[0]);
                void'(exp_value_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    initial begin
        bit          fires;
        logic [31:0] rnd_word;
        int          wait_cnt;
        bit          timed_out;
        int          total;
        seed       = 32'h7391_ddb6;
        timed_out  = 1'b0;
        rst        = 1'b0;
        shift_en   = 1'b0;
        start_row  = 1'b0;
        weight_en  = 1'b0;
        column_in  = '0;
        weight_row = '0;
        weights_in = '0;
        model_fill = 0;
        for (int k = 0; k < conv_pkg::KERNEL; k++) begin
            model_cols[k] = '0;
            model_w[k]    = '0;
        end
        for (int i = 0; i < STIM_LEN; i++) begin
            if (stim_table[i].rnd) begin
                rnd_word                = $random(seed);
                stim_table[i].column    = rnd_word[23:0];
                rnd_word                = $random(seed);
                stim_table[i].weights   = rnd_word[23:0];
            end
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < STIM_LEN; i++) begin
            @(negedge clk);
            drive_inputs(stim_table[i]);
            fires = update_model(stim_table[i]);
            assert (fires == stim_table[i].exp_out) else begin
                err_table++;
                $display("** Error at %0d ns: entry %0d expect flag %0b, model gives %0b",
                         $time, i, stim_table[i].exp_out, fires);
            end
            if (fires) begin
                exp_value_q.push_back(expected_ofmap());
                exp_due_q.push_back(edge_cnt + 3);
            end
        end
        @(negedge clk);
        drive_inputs('0);

        // drain the pipeline
        wait_cnt = 0;
        while (exp_value_q.size() > 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_value_q.size() > 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d expected results still outstanding", exp_value_q.size());
        end else begin
            repeat (4) @(posedge clk);
        end

        total = err_value + err_timing + err_extra + err_missing + err_table;
        $display("errors: value %0d, timing %0d, unexpected %0d, missing %0d, table %0d",
                 err_value, err_timing, err_extra, err_missing, err_table);
        if (!timed_out && total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* conv_engine.f */
+incdir+verif
source/conv_pkg.sv
source/window_if.sv
source/window_buffer.sv
source/pe_row.sv
source/psum_adder.sv
source/conv_engine.sv
verif/conv_engine_tb.sv

/* Makefile */
TOP = conv_engine_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f conv_engine.f

# pass only if the pass message shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
